//--- verilog/drawSettings.svh
`ifndef DRAW_SETTINGS_SVH
`define DRAW_SETTINGS_SVH

// Frame geometry, in four-pixel words.
`define DRAW_WORDS_PER_ROW    16
`define DRAW_ROWS             8

// RGB565 palette.
`define DRAW_COLOR_BACKGROUND 16'h0841
`define DRAW_COLOR_BORDER     16'hffe0 // Yellow.
`define DRAW_COLOR_WAVE       16'h07e0 // Green.
`define DRAW_COLOR_CURSOR     16'hf800 // Red.
`define DRAW_COLOR_BIT        16'hffff // White.

// Wave bar limits.
`define DRAW_MAX_PERIODS      3'd5
`define DRAW_WORDS_PER_PERIOD 3

// Target rows of the refresh pass. Border uses rows 0 and 7.
`define DRAW_ROW_WAVE         3'd1
`define DRAW_ROW_CURSOR       3'd2
`define DRAW_ROW_PULSE        3'd3
`define DRAW_ROW_ACCUM        3'd4

// Wishbone word addresses.
`define DRAW_REG_CTRL         2'd0
`define DRAW_REG_PULSE        2'd1
`define DRAW_REG_ACCUM        2'd2
`define DRAW_REG_STATUS       2'd3

// CTRL field positions.
`define DRAW_CTRL_ENABLE      0
`define DRAW_CTRL_PERIODS_HI  6
`define DRAW_CTRL_PERIODS_LO  4
`define DRAW_CTRL_GAIN_HI     9
`define DRAW_CTRL_GAIN_LO     8
`define DRAW_CTRL_CURSOR_HI   15
`define DRAW_CTRL_CURSOR_LO   12

`endif

//--- verilog/drawPkg.sv
package drawPkg;

    // Bank(2) + row(13) + column(9). Column is word index times 4.
    typedef logic [23:0] sdramAddr;
    typedef logic [15:0] pixel;       // RGB565.
    typedef logic [31:0] counterWord; // Pulse and accumulated counters.
    typedef logic [3:0]  cursorIndex;
    typedef logic [2:0]  periodCount;
    typedef logic [1:0]  gainShift;   // Right shift of the pulse counter.

    // Drawing commands understood by the core.
    typedef enum logic [2:0] {
        cmdClear,
        cmdBorder,
        cmdWave,
        cmdCursor,
        cmdBits
    } drawCmd;

    // Scheduler steps, power-on first, then the refresh loop.
    typedef enum logic [2:0] {
        schedSettle,
        schedClear,
        schedBorder,
        schedWave,
        schedCursor,
        schedPulse,
        schedAccum
    } schedState;

    typedef enum logic [1:0] {
        coreIdle,
        coreWrite,
        coreDone
    } coreState;

endpackage

//--- verilog/drawRegs.sv
`timescale 1ns/10ps
`include "drawSettings.svh"

module drawRegs import drawPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Wishbone classic slave.
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] datIn,
    output logic        ack,
    output logic [31:0] datOut,
    // Scheduler side.
    input  logic        passDone,
    input  logic        pulseTaken,
    output logic        enable,
    output periodCount  periods,
    output cursorIndex  cursor,
    output gainShift    gain,
    output counterWord  pulseValue,
    output counterWord  accumValue,
    output logic        pulsePending
);

    logic [31:0] ctrlReg;
    logic [15:0] passCount; // STATUS[15:0].
    logic        access;    // New strobe, not yet acked.

    assign access = cyc && stb && !ack;

    ////////////////////////////////////////////////////////////////////////////
    // Register writes and single-cycle ack.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            ctrlReg    <= '0;
            pulseValue <= '0;
            accumValue <= '0;
        end else begin
            ack <= access; // One ack per strobe.
            if (access && we) begin
                case (adr)
                    `DRAW_REG_CTRL:  ctrlReg    <= datIn;
                    `DRAW_REG_PULSE: pulseValue <= datIn;
                    `DRAW_REG_ACCUM: accumValue <= datIn;
                    default: ; // STATUS is read-only.
                endcase
            end
        end
    end

    // New counter flag, a fresh write wins over a take.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pulsePending <= 1'b0;
        end else if (access && we && adr == `DRAW_REG_PULSE) begin
            pulsePending <= 1'b1;
        end else if (pulseTaken) begin
            pulsePending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            passCount <= '0;
        end else if (passDone) begin
            passCount <= passCount + 16'd1; // Wraps.
        end
    end

    // Read data, valid with ack.
    always_ff @(posedge clk) begin
        if (access && !we) begin
            case (adr)
                `DRAW_REG_CTRL:  datOut <= ctrlReg;
                `DRAW_REG_PULSE: datOut <= pulseValue;
                `DRAW_REG_ACCUM: datOut <= accumValue;
                default:         datOut <= {16'd0, passCount};
            endcase
        end
    end

    // CTRL fields.
    assign enable  = ctrlReg[`DRAW_CTRL_ENABLE];
    assign periods = ctrlReg[`DRAW_CTRL_PERIODS_HI:`DRAW_CTRL_PERIODS_LO];
    assign gain    = ctrlReg[`DRAW_CTRL_GAIN_HI:`DRAW_CTRL_GAIN_LO];
    assign cursor  = ctrlReg[`DRAW_CTRL_CURSOR_HI:`DRAW_CTRL_CURSOR_LO];

    // Ack only answers a live strobe.
    ackNeedsStb: assert property (@(posedge clk) disable iff (!rst_n) ack |-> stb);

endmodule

//--- verilog/drawScheduler.sv
`timescale 1ns/10ps
`include "drawSettings.svh"

module drawScheduler import drawPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  periodCount  periods,
    input  cursorIndex  cursor,
    input  gainShift    gain,
    input  counterWord  pulseValue,
    input  counterWord  accumValue,
    input  logic        pulsePending,
    input  logic        busy,
    input  logic        done,
    output logic        start,
    output drawCmd      cmd,
    output logic [2:0]  row,
    output counterWord  arg,
    output logic        pulseTaken,
    output logic        passDone,
    output logic        led
);

    schedState  state;
    schedState  nextState;
    logic       issued;    // Command of this step is running.
    logic       issue;
    drawCmd     stepCmd;
    logic [2:0] stepRow;
    counterWord stepArg;
    periodCount periodsClamped;
    cursorIndex cursorQ;   // Per-pass copies.
    gainShift   gainQ;
    counterWord pulseQ;

    assign periodsClamped = (periods > `DRAW_MAX_PERIODS) ? `DRAW_MAX_PERIODS : periods;
    assign issue = (state != schedSettle) && !issued && enable && !busy;

    // Taken on the edge that copies pulseQ.
    assign pulseTaken = issue && (state == schedWave) && pulsePending;

    ////////////////////////////////////////////////////////////////////////////
    // Step decode.

    always_comb begin
        stepCmd   = cmdClear;
        stepRow   = 3'd0;
        stepArg   = '0;
        nextState = schedWave; // Loop back after the accumulated row.
        case (state)
            schedSettle: nextState = schedClear;
            schedClear: begin
                stepArg   = {16'd0, `DRAW_COLOR_BACKGROUND};
                nextState = schedBorder;
            end
            schedBorder: stepCmd = cmdBorder; // Core picks rows 0 and 7.
            schedWave: begin
                stepCmd   = cmdWave;
                stepRow   = `DRAW_ROW_WAVE;
                stepArg   = {29'd0, periodsClamped}; // Clamped live value.
                nextState = schedCursor;
            end
            schedCursor: begin
                stepCmd   = cmdCursor;
                stepRow   = `DRAW_ROW_CURSOR;
                stepArg   = {28'd0, cursorQ};
                nextState = schedPulse;
            end
            schedPulse: begin
                stepCmd   = cmdBits;
                stepRow   = `DRAW_ROW_PULSE;
                stepArg   = pulseQ >> gainQ; // Gain divider.
                nextState = schedAccum;
            end
            default: begin
                stepCmd = cmdBits;
                stepRow = `DRAW_ROW_ACCUM;
                stepArg = accumValue; // Unscaled.
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step sequencing.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= schedSettle;
            issued     <= 1'b0;
            start      <= 1'b0;
            passDone   <= 1'b0;
            led        <= 1'b0;
            cursorQ    <= '0;
            gainQ      <= '0;
            pulseQ     <= '0;
        end else begin
            start      <= 1'b0;
            passDone   <= 1'b0;
            if (state == schedSettle) begin
                state <= nextState; // One idle cycle after reset.
            end else if (issued) begin
                if (done) begin
                    issued <= 1'b0;
                    state  <= nextState;
                    if (state == schedAccum) begin
                        passDone <= 1'b1; // End of a refresh pass.
                        led      <= ~led;
                    end
                end
            end else if (issue) begin
                start  <= 1'b1;
                issued <= 1'b1;
                if (state == schedWave) begin // Start of a pass.
                    cursorQ <= cursor;
                    gainQ   <= gain;
                    if (pulsePending) begin
                        pulseQ <= pulseValue;
                    end
                end
            end
        end
    end

    // Command payload for the core, sampled with start.
    always_ff @(posedge clk) begin
        if (issue) begin
            cmd <= stepCmd;
            row <= stepRow;
            arg <= stepArg;
        end
    end

    // Never hand a command to a busy core.
    startWhenIdle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

//--- verilog/drawCore.sv
`timescale 1ns/10ps
`include "drawSettings.svh"

module drawCore import drawPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // Command side.
    input  logic       start,
    input  drawCmd     cmd,
    input  logic [2:0] row,
    input  counterWord arg,
    output logic       busy,
    output logic       done,
    // Frame-buffer write port.
    output logic       wrReq,
    output sdramAddr   wrAddr,
    output pixel       wrData1,
    output pixel       wrData2,
    output pixel       wrData3,
    output pixel       wrData4,
    input  logic       wrDone
);

    localparam logic [3:0] LastCol = 4'(`DRAW_WORDS_PER_ROW - 1);
    localparam logic [2:0] LastRow = 3'(`DRAW_ROWS - 1);

    coreState   state;
    drawCmd     cmdQ;
    counterWord argQ;
    logic [2:0] rowQ;      // Current target row.
    logic [3:0] wordIdx;   // Word within the row.
    logic       multiRow;  // Clear and border span rows.
    logic       lastWord;
    logic [4:0] waveLimit; // Words covered by the bar.
    logic [4:0] bitIdx;
    pixel       pix [4];

    assign multiRow  = (cmdQ == cmdClear) || (cmdQ == cmdBorder);
    assign lastWord  = (wordIdx == LastCol) && (!multiRow || rowQ == LastRow);
    assign waveLimit = 5'(argQ[2:0]) * 5'(`DRAW_WORDS_PER_PERIOD);

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= coreIdle;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                coreIdle: begin
                    if (start) begin
                        busy  <= 1'b1;
                        state <= coreWrite;
                    end
                end
                coreWrite: begin
                    if (wrDone && lastWord) state <= coreDone; // Drop wrReq.
                end
                coreDone: begin
                    done  <= 1'b1; // Done and busy change together.
                    busy  <= 1'b0;
                    state <= coreIdle;
                end
                default: state <= coreIdle;
            endcase
        end
    end

    // Command copy and word walk.
    always_ff @(posedge clk) begin
        if (state == coreIdle && start) begin
            cmdQ    <= cmd;
            argQ    <= arg;
            rowQ    <= (cmd == cmdClear || cmd == cmdBorder) ? 3'd0 : row;
            wordIdx <= '0;
        end else if (state == coreWrite && wrDone && !lastWord) begin
            wordIdx <= wordIdx + 4'd1;
            if (wordIdx == LastCol) begin
                // Border jumps from top row to bottom row.
                rowQ <= (cmdQ == cmdBorder) ? LastRow : rowQ + 3'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pixel forming.

    always_comb begin
        bitIdx = '0;
        for (int p = 0; p < 4; p++) begin
            bitIdx = {wordIdx[2:0], 2'(p)}; // Bit k = word*4 + p.
            case (cmdQ)
                cmdClear:  pix[p] = argQ[15:0];
                cmdBorder: pix[p] = `DRAW_COLOR_BORDER;
                cmdWave:
                    pix[p] = ({1'b0, wordIdx} < waveLimit) ? `DRAW_COLOR_WAVE
                                                           : `DRAW_COLOR_BACKGROUND;
                cmdCursor:
                    pix[p] = (wordIdx == argQ[3:0]) ? `DRAW_COLOR_CURSOR
                                                    : `DRAW_COLOR_BACKGROUND;
                default: // Bits, upper half of the row stays blank.
                    pix[p] = (!wordIdx[3] && argQ[bitIdx]) ? `DRAW_COLOR_BIT
                                                           : `DRAW_COLOR_BACKGROUND;
            endcase
        end
    end

    assign wrReq   = (state == coreWrite);
    assign wrAddr  = {2'b00, 10'd0, rowQ, 3'd0, wordIdx, 2'b00}; // Bank 0.
    assign wrData1 = pix[0]; // Leftmost pixel.
    assign wrData2 = pix[1];
    assign wrData3 = pix[2];
    assign wrData4 = pix[3];

    // Request payload holds until the controller answers.
    wrHeld: assert property (@(posedge clk) disable iff (!rst_n)
        wrReq && !wrDone |=> wrReq && $stable(wrAddr) && $stable(wrData1)
                             && $stable(wrData2) && $stable(wrData3) && $stable(wrData4));

endmodule

//--- verilog/displayDrawSystem.sv
`timescale 1ns/10ps

module displayDrawSystem import drawPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Wishbone classic slave.
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] datIn,
    output logic        ack,
    output logic [31:0] datOut,
    // Frame-buffer SDRAM write port.
    output logic        wrReq,
    output sdramAddr    wrAddr,
    output pixel        wrData1,
    output pixel        wrData2,
    output pixel        wrData3,
    output pixel        wrData4,
    input  logic        wrDone,
    output logic        led     // Heartbeat, one toggle per pass.
);

    // Register block to scheduler.
    logic       enable;
    periodCount periods;
    cursorIndex cursor;
    gainShift   gain;
    counterWord pulseValue;
    counterWord accumValue;
    logic       pulsePending;
    logic       pulseTaken;
    logic       passDone;

    // Scheduler to core.
    logic       start;
    logic       busy;
    logic       done;
    drawCmd     cmd;
    logic [2:0] row;
    counterWord arg;

    drawRegs regs (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
        .ack(ack), .datOut(datOut),
        .passDone(passDone), .pulseTaken(pulseTaken),
        .enable(enable), .periods(periods), .cursor(cursor), .gain(gain),
        .pulseValue(pulseValue), .accumValue(accumValue), .pulsePending(pulsePending)
    );

    drawScheduler scheduler (
        .clk(clk), .rst_n(rst_n),
        .enable(enable), .periods(periods), .cursor(cursor), .gain(gain),
        .pulseValue(pulseValue), .accumValue(accumValue), .pulsePending(pulsePending),
        .busy(busy), .done(done),
        .start(start), .cmd(cmd), .row(row), .arg(arg),
        .pulseTaken(pulseTaken), .passDone(passDone), .led(led)
    );

    drawCore core (
        .clk(clk), .rst_n(rst_n),
        .start(start), .cmd(cmd), .row(row), .arg(arg),
        .busy(busy), .done(done),
        .wrReq(wrReq), .wrAddr(wrAddr),
        .wrData1(wrData1), .wrData2(wrData2), .wrData3(wrData3), .wrData4(wrData4),
        .wrDone(wrDone)
    );

endmodule

//--- test/tbDisplayDraw.sv
`timescale 1ns/10ps
`include "drawSettings.svh"

module tbDisplayDraw import drawPkg::*; ();

    localparam int TestCount     = 6;
    localparam int PassesPerTest = 3;
    localparam int CyclesPerPass = 600;
    localparam int ClockPeriod   = 20; // ns.

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] datIn;
    logic        ack;
    logic [31:0] datOut;
    logic        wrReq;
    sdramAddr    wrAddr;
    pixel        wrData1;
    pixel        wrData2;
    pixel        wrData3;
    pixel        wrData4;
    logic        wrDone;
    logic        led;

    logic [31:0] lcgState = 32'hafec_20fb;
    logic [63:0] frameMem [0:127]; // Indexed by row*16 + word. Pixel 0 in the low bits.
    int          writeCount = 0;
    int          ledToggles = 0;
    logic        ledLast = 1'b0;
    int          waitLeft;         // Responder delay still to go.
    logic        armed;
    logic [31:0] delayDraw;
    int          errorCount = 0;
    int          errorsAtStart;
    int          testsRun = 0;
    int          testsFailed = 0;
    string       currentTest = "reset";

    // Frame model inputs.
    int          periodsSet;
    int          cursorSet;
    int          gainSet;
    logic [31:0] pulseRaw;
    logic [31:0] accumSet;

    displayDrawSystem uut (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
        .ack(ack), .datOut(datOut),
        .wrReq(wrReq), .wrAddr(wrAddr),
        .wrData1(wrData1), .wrData2(wrData2), .wrData3(wrData3), .wrData4(wrData4),
        .wrDone(wrDone), .led(led)
    );

    always #(ClockPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] ctrlWord(input logic en, input logic [2:0] p,
                                             input logic [1:0] g, input logic [3:0] c);
        logic [31:0] value;
        value = '0;
        value[`DRAW_CTRL_ENABLE] = en;
        value[`DRAW_CTRL_PERIODS_HI:`DRAW_CTRL_PERIODS_LO] = p;
        value[`DRAW_CTRL_GAIN_HI:`DRAW_CTRL_GAIN_LO] = g;
        value[`DRAW_CTRL_CURSOR_HI:`DRAW_CTRL_CURSOR_LO] = c;
        return value;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Frame model of one word from the drawing rules.

    function automatic logic [63:0] expectedWord(input int r, input int w);
        logic [63:0] word;
        logic [31:0] pulseShown;
        pixel        color;
        int          limit;
        int          k;
        int          p;
        word       = '0;
        pulseShown = pulseRaw >> gainSet; // Gain divider.
        limit      = ((periodsSet > `DRAW_MAX_PERIODS) ? `DRAW_MAX_PERIODS : periodsSet)
                     * `DRAW_WORDS_PER_PERIOD;
        for (p = 0; p < 4; p++) begin
            k     = w * 4 + p; // Bit index in a counter row.
            color = `DRAW_COLOR_BACKGROUND;
            if (r == 0 || r == `DRAW_ROWS - 1) color = `DRAW_COLOR_BORDER;
            else if (r == `DRAW_ROW_WAVE && w < limit) color = `DRAW_COLOR_WAVE;
            else if (r == `DRAW_ROW_CURSOR && w == cursorSet) color = `DRAW_COLOR_CURSOR;
            else if (r == `DRAW_ROW_PULSE && k < 32 && pulseShown[k]) color = `DRAW_COLOR_BIT;
            else if (r == `DRAW_ROW_ACCUM && k < 32 && accumSet[k]) color = `DRAW_COLOR_BIT;
            word[16 * p +: 16] = color;
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM controller stand-in with a random 0 to 3 cycle answer.

    always @(posedge clk) begin
        if (!rst_n) begin
            wrDone <= 1'b0;
            armed = 1'b0;
        end else if (wrDone) begin
            wrDone <= 1'b0; // One-cycle pulse.
        end else if (wrReq) begin
            if (!armed) begin
                armed     = 1'b1;
                delayDraw = nextRandom();
                waitLeft  = delayDraw[17:16];
            end
            if (waitLeft == 0) begin
                if (wrAddr[23:22] != 2'b00 || wrAddr[21:9] >= `DRAW_ROWS ||
                    wrAddr[1:0] != 2'b00 || wrAddr[8:2] >= `DRAW_WORDS_PER_ROW) begin
                    $display("SDRAM write outside the 16x8 frame, address %h", wrAddr);
                    errorCount++;
                end else begin
                    frameMem[wrAddr[21:9] * 16 + wrAddr[8:2]] <=
                        {wrData4, wrData3, wrData2, wrData1};
                end
                writeCount <= writeCount + 1;
                wrDone     <= 1'b1;
                armed = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

    // Heartbeat edge counter.
    always @(posedge clk) begin
        if (rst_n && led !== ledLast) ledToggles <= ledToggles + 1;
        ledLast <= led;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master and check helpers.

    task automatic busWrite(input logic [1:0] a, input logic [31:0] d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        datIn <= d;
        @(posedge clk);
        while (ack !== 1'b1) @(posedge clk);
        cyc <= 1'b0; // Drop the strobe after ack.
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic busRead(input logic [1:0] a, output logic [31:0] d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        @(posedge clk);
        while (ack !== 1'b1) @(posedge clk);
        d = datOut; // Valid with ack.
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    // Polls STATUS until n more passes are counted.
    task automatic waitPasses(input int n);
        logic [31:0] first;
        logic [31:0] now;
        busRead(`DRAW_REG_STATUS, first);
        now = first;
        while (16'(now[15:0] - first[15:0]) < n) busRead(`DRAW_REG_STATUS, now);
    endtask

    task automatic reportMismatch(input string what, input logic [63:0] expVal,
                                  input logic [63:0] actVal);
        $display("** Error: test %s, %s: expected %h, actual %h",
                 currentTest, what, expVal, actVal);
        errorCount++;
    endtask

    task automatic compareRow(input int r);
        logic [63:0] expVal;
        logic [63:0] actVal;
        int          w;
        for (w = 0; w < `DRAW_WORDS_PER_ROW; w++) begin
            expVal = expectedWord(r, w);
            actVal = frameMem[r * 16 + w];
            if (actVal !== expVal)
                reportMismatch($sformatf("row %0d word %0d", r, w), expVal, actVal);
        end
    endtask

    task automatic beginTest(input string name);
        currentTest   = name;
        errorsAtStart = errorCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errorCount != errorsAtStart) testsFailed++;
        $display("test %s %s", currentTest, (errorCount == errorsAtStart) ? "passed" : "failed");
    endtask

    // Budget of passes per test.
    initial begin
        #(TestCount * PassesPerTest * CyclesPerPass * ClockPeriod);
        $display("Watchdog timeout, test %s hung", currentTest);
        $display("FAIL: see errors above");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence.

    initial begin
        logic [31:0] readData;
        logic [31:0] ctrlValue;
        logic [31:0] statusA;
        logic [31:0] statusB;
        int          togglesA;
        int          writesA;
        int          quiet;
        int          r;
        rst_n  <= 1'b0;
        cyc    <= 1'b0;
        stb    <= 1'b0;
        we     <= 1'b0;
        adr    <= '0;
        datIn  <= '0;
        wrDone <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        beginTest("reset");
        if (wrReq !== 1'b0) reportMismatch("wrReq after reset", 0, wrReq);
        if (led !== 1'b0) reportMismatch("led after reset", 0, led);
        if (ack !== 1'b0) reportMismatch("ack after reset", 0, ack);
        pulseRaw  = nextRandom();
        accumSet  = nextRandom();
        ctrlValue = nextRandom() | 32'd1; // Enable forced on.
        busWrite(`DRAW_REG_PULSE, pulseRaw);
        busWrite(`DRAW_REG_ACCUM, accumSet);
        busWrite(`DRAW_REG_CTRL, ctrlValue);
        periodsSet = ctrlValue[`DRAW_CTRL_PERIODS_HI:`DRAW_CTRL_PERIODS_LO];
        gainSet    = ctrlValue[`DRAW_CTRL_GAIN_HI:`DRAW_CTRL_GAIN_LO];
        cursorSet  = ctrlValue[`DRAW_CTRL_CURSOR_HI:`DRAW_CTRL_CURSOR_LO];
        busRead(`DRAW_REG_CTRL, readData);
        if (readData !== ctrlValue) reportMismatch("CTRL readback", ctrlValue, readData);
        busRead(`DRAW_REG_PULSE, readData);
        if (readData !== pulseRaw) reportMismatch("PULSE readback", pulseRaw, readData);
        busRead(`DRAW_REG_ACCUM, readData);
        if (readData !== accumSet) reportMismatch("ACCUM readback", accumSet, readData);
        endTest();

        beginTest("border");
        waitPasses(2);
        compareRow(0);
        compareRow(5); // Left from the clear.
        compareRow(6);
        compareRow(7);
        endTest();

        beginTest("wave");
        readData   = nextRandom();
        periodsSet = readData[18:16]; // Covers 0 to 7 including clamped values.
        cursorSet  = readData[23:20];
        busWrite(`DRAW_REG_CTRL, ctrlWord(1'b1, periodsSet, gainSet, cursorSet));
        waitPasses(2);
        compareRow(`DRAW_ROW_WAVE);
        compareRow(`DRAW_ROW_CURSOR);
        endTest();

        beginTest("pulse");
        readData = nextRandom();
        gainSet  = readData[17:16];
        pulseRaw = nextRandom();
        busWrite(`DRAW_REG_CTRL, ctrlWord(1'b1, periodsSet, gainSet, cursorSet));
        busWrite(`DRAW_REG_PULSE, pulseRaw);
        waitPasses(2);
        compareRow(`DRAW_ROW_PULSE);
        accumSet = nextRandom(); // Only the other counter moves.
        busWrite(`DRAW_REG_ACCUM, accumSet);
        waitPasses(2);
        compareRow(`DRAW_ROW_PULSE);
        endTest();

        beginTest("accum");
        accumSet = nextRandom();
        busWrite(`DRAW_REG_ACCUM, accumSet);
        waitPasses(2);
        compareRow(`DRAW_ROW_ACCUM);
        endTest();

        beginTest("enable");
        busWrite(`DRAW_REG_CTRL, ctrlWord(1'b0, periodsSet, gainSet, cursorSet));
        quiet = 0;
        while (quiet < 20) begin // Running command drains first.
            @(posedge clk);
            quiet = wrReq ? 0 : quiet + 1;
        end
        busRead(`DRAW_REG_STATUS, statusA);
        togglesA = ledToggles;
        writesA  = writeCount;
        repeat (400) @(posedge clk);
        busRead(`DRAW_REG_STATUS, statusB);
        if (statusB !== statusA) reportMismatch("STATUS while disabled", statusA, statusB);
        if (ledToggles != togglesA) reportMismatch("led toggles while disabled",
                                                   togglesA, ledToggles);
        if (writeCount != writesA) reportMismatch("SDRAM writes while disabled",
                                                  writesA, writeCount);
        busWrite(`DRAW_REG_CTRL, ctrlWord(1'b1, periodsSet, gainSet, cursorSet));
        waitPasses(2);
        if (ledToggles == togglesA) begin
            $display("Test %s: led did not toggle after enable was set again", currentTest);
            errorCount++;
        end
        for (r = 0; r < `DRAW_ROWS; r++) compareRow(r); // Whole frame.
        endTest();

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- displayDrawSystem.f
+incdir+verilog
verilog/drawPkg.sv
verilog/drawRegs.sv
verilog/drawScheduler.sv
verilog/drawCore.sv
verilog/displayDrawSystem.sv
test/tbDisplayDraw.sv
